// ==== src/mips_pkg.sv ====
package mips_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int REG_NUM    = 32;
	localparam int ALUOP_W    = 4;

	// ALU operations
	localparam logic [ALUOP_W-1:0] ALU_NOP  = 4'd0;
	localparam logic [ALUOP_W-1:0] ALU_OR   = 4'd1;
	localparam logic [ALUOP_W-1:0] ALU_AND  = 4'd2;
	localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'd3;
	localparam logic [ALUOP_W-1:0] ALU_NOR  = 4'd4;
	localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'd5;
	localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'd6;
	localparam logic [ALUOP_W-1:0] ALU_SRA  = 4'd7;
	localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'd8;
	localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'd9;
	localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'd10;
	localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'd11;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;

	// SPECIAL function field
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// Instruction word in register or immediate view
	typedef union packed {
		struct packed {
			logic [5:0]            op;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [REG_ADDR_W-1:0] rd;
			logic [REG_ADDR_W-1:0] shamt;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            op;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [15:0]           imm;
		} i;
	} inst_u;

endpackage

// ==== src/decode_stage.sv ====
module decode_stage (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            inst_valid_i,
	input  mips_pkg::inst_u                 inst_i,
	input  logic [mips_pkg::DATA_W-1:0]     pc_i,
	input  logic [mips_pkg::DATA_W-1:0]     reg1_data_i,
	input  logic [mips_pkg::DATA_W-1:0]     reg2_data_i,
	input  logic [mips_pkg::DATA_W-1:0]     ex_result_i,
	input  logic                            mem_wreg_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0] mem_wd_i,
	input  logic [mips_pkg::DATA_W-1:0]     mem_wdata_i,
	output logic [mips_pkg::REG_ADDR_W-1:0] reg1_addr_o,
	output logic [mips_pkg::REG_ADDR_W-1:0] reg2_addr_o,
	output logic [mips_pkg::ALUOP_W-1:0]    aluop_o,
	output logic [mips_pkg::DATA_W-1:0]     reg1_o,
	output logic [mips_pkg::DATA_W-1:0]     reg2_o,
	output logic [mips_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                            wreg_o,
	output logic                            branch_o,
	output logic [mips_pkg::DATA_W-1:0]     branch_target_o
);

	logic [mips_pkg::ALUOP_W-1:0]    fn_aluop;
	logic [mips_pkg::ALUOP_W-1:0]    dec_aluop;
	logic                            dec_wreg;
	logic [mips_pkg::REG_ADDR_W-1:0] dec_wd;
	logic                            reg1_read;
	logic                            reg2_read;
	logic [mips_pkg::DATA_W-1:0]     imm;
	logic [mips_pkg::DATA_W-1:0]     imm_zext;
	logic [mips_pkg::DATA_W-1:0]     imm_sext;
	logic [mips_pkg::DATA_W-1:0]     imm_upper;
	logic [mips_pkg::DATA_W-1:0]     imm_shamt;
	logic [mips_pkg::DATA_W-1:0]     reg1_val;
	logic [mips_pkg::DATA_W-1:0]     reg2_val;
	logic [mips_pkg::DATA_W-1:0]     br_target;
	logic                            br_taken;
	logic                            wr_en;

	// Execute first, then its output register, then the file
	function automatic logic [mips_pkg::DATA_W-1:0] fwd_operand(
		input logic                            rd_en,
		input logic [mips_pkg::REG_ADDR_W-1:0] addr,
		input logic [mips_pkg::DATA_W-1:0]     rf_data,
		input logic [mips_pkg::DATA_W-1:0]     imm_val,
		input logic                            ex_wreg,
		input logic [mips_pkg::REG_ADDR_W-1:0] ex_wd,
		input logic [mips_pkg::DATA_W-1:0]     ex_data,
		input logic                            mem_wreg,
		input logic [mips_pkg::REG_ADDR_W-1:0] mem_wd,
		input logic [mips_pkg::DATA_W-1:0]     mem_data
	);
		if (!rd_en) begin
			return imm_val;
		end else if (ex_wreg && ex_wd == addr) begin
			return ex_data;
		end else if (mem_wreg && mem_wd == addr) begin
			return mem_data;
		end
		return rf_data;
	endfunction

	assign reg1_addr_o = inst_i.r.rs;
	assign reg2_addr_o = inst_i.r.rt;

	assign imm_zext  = {{(mips_pkg::DATA_W-16){1'b0}}, inst_i.i.imm};
	assign imm_sext  = {{(mips_pkg::DATA_W-16){inst_i.i.imm[15]}}, inst_i.i.imm};
	assign imm_upper = {inst_i.i.imm, {(mips_pkg::DATA_W-16){1'b0}}};
	assign imm_shamt = {{(mips_pkg::DATA_W-mips_pkg::REG_ADDR_W){1'b0}}, inst_i.r.shamt};

	always_comb begin
		case (inst_i.r.funct)
			mips_pkg::FN_OR:   fn_aluop = mips_pkg::ALU_OR;
			mips_pkg::FN_AND:  fn_aluop = mips_pkg::ALU_AND;
			mips_pkg::FN_XOR:  fn_aluop = mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  fn_aluop = mips_pkg::ALU_NOR;
			mips_pkg::FN_SLL,
			mips_pkg::FN_SLLV: fn_aluop = mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL,
			mips_pkg::FN_SRLV: fn_aluop = mips_pkg::ALU_SRL;
			mips_pkg::FN_SRA,
			mips_pkg::FN_SRAV: fn_aluop = mips_pkg::ALU_SRA;
			mips_pkg::FN_ADDU: fn_aluop = mips_pkg::ALU_ADD;
			mips_pkg::FN_SUBU: fn_aluop = mips_pkg::ALU_SUB;
			mips_pkg::FN_SLT:  fn_aluop = mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: fn_aluop = mips_pkg::ALU_SLTU;
			default:           fn_aluop = mips_pkg::ALU_NOP;
		endcase
	end

	always_comb begin
		dec_aluop = mips_pkg::ALU_NOP;
		dec_wreg  = 1'b0;
		dec_wd    = inst_i.i.rt; // Immediate forms write rt
		reg1_read = 1'b0;
		reg2_read = 1'b0;
		imm       = imm_sext;
		case (inst_i.i.op)
			mips_pkg::OP_SPECIAL: begin
				dec_wd = inst_i.r.rd;
				if (fn_aluop != mips_pkg::ALU_NOP) begin
					dec_aluop = fn_aluop;
					if (inst_i.r.funct == mips_pkg::FN_SLL || inst_i.r.funct == mips_pkg::FN_SRL ||
					    inst_i.r.funct == mips_pkg::FN_SRA) begin
						dec_wreg  = (inst_i.r.rs == '0); // Shift amount from shamt
						reg2_read = 1'b1;
						imm       = imm_shamt;
					end else begin
						dec_wreg  = (inst_i.r.shamt == '0);
						reg1_read = 1'b1;
						reg2_read = 1'b1;
					end
				end
			end
			mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI: begin
				dec_aluop = (inst_i.i.op == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR :
				            (inst_i.i.op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
				                                                 mips_pkg::ALU_XOR;
				dec_wreg  = 1'b1;
				reg1_read = 1'b1;
				imm       = imm_zext;
			end
			mips_pkg::OP_LUI: begin
				dec_aluop = mips_pkg::ALU_OR; // imm | imm
				dec_wreg  = 1'b1;
				imm       = imm_upper;
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				dec_aluop = (inst_i.i.op == mips_pkg::OP_ADDIU) ? mips_pkg::ALU_ADD :
				            (inst_i.i.op == mips_pkg::OP_SLTI)  ? mips_pkg::ALU_SLT :
				                                                  mips_pkg::ALU_SLTU;
				dec_wreg  = 1'b1;
				reg1_read = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				reg1_read = 1'b1;
				reg2_read = 1'b1;
			end
			mips_pkg::OP_BGTZ, mips_pkg::OP_BLEZ: begin
				reg1_read = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign reg1_val = fwd_operand(reg1_read, inst_i.r.rs, reg1_data_i, imm,
		wreg_o, wd_o, ex_result_i, mem_wreg_i, mem_wd_i, mem_wdata_i);
	assign reg2_val = fwd_operand(reg2_read, inst_i.r.rt, reg2_data_i, imm,
		wreg_o, wd_o, ex_result_i, mem_wreg_i, mem_wd_i, mem_wdata_i);

	assign br_target = pc_i + 32'd4 + {imm_sext[mips_pkg::DATA_W-3:0], 2'b00};

	always_comb begin
		case (inst_i.i.op)
			mips_pkg::OP_BEQ:  br_taken = (reg1_val == reg2_val);
			mips_pkg::OP_BNE:  br_taken = (reg1_val != reg2_val);
			mips_pkg::OP_BGTZ: br_taken = !reg1_val[mips_pkg::DATA_W-1] && reg1_val != '0;
			mips_pkg::OP_BLEZ: br_taken = reg1_val[mips_pkg::DATA_W-1] || reg1_val == '0;
			default:           br_taken = 1'b0;
		endcase
	end

	assign wr_en = inst_valid_i && dec_wreg && dec_wd != '0; // r0 writes become bubbles

	always_ff @(posedge clk) begin
		if (reset_i) begin
			aluop_o  <= mips_pkg::ALU_NOP;
			wreg_o   <= 1'b0;
			branch_o <= 1'b0;
		end else begin
			aluop_o  <= wr_en ? dec_aluop : mips_pkg::ALU_NOP;
			wreg_o   <= wr_en;
			branch_o <= inst_valid_i && br_taken;
		end
	end

	always_ff @(posedge clk) begin
		reg1_o          <= reg1_val;
		reg2_o          <= reg2_val;
		wd_o            <= dec_wd;
		branch_target_o <= br_target;
	end

	a_branch_no_write: assert property (@(posedge clk) disable iff (reset_i)
		!(branch_o && wreg_o))
		else $error("branch issued together with a register write");

endmodule

// ==== src/execute_stage.sv ====
module execute_stage (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic [mips_pkg::ALUOP_W-1:0]    aluop_i,
	input  logic [mips_pkg::DATA_W-1:0]     reg1_i,
	input  logic [mips_pkg::DATA_W-1:0]     reg2_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                            wreg_i,
	output logic [mips_pkg::DATA_W-1:0]     ex_result_o,
	output logic [mips_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                            wreg_o,
	output logic [mips_pkg::DATA_W-1:0]     wdata_o
);

	logic [mips_pkg::REG_ADDR_W-1:0] shamt;

	assign shamt = reg1_i[mips_pkg::REG_ADDR_W-1:0]; // Shift amount rides on operand 1

	always_comb begin
		case (aluop_i)
			mips_pkg::ALU_OR: begin
				ex_result_o = reg1_i | reg2_i;
			end
			mips_pkg::ALU_AND: begin
				ex_result_o = reg1_i & reg2_i;
			end
			mips_pkg::ALU_XOR: begin
				ex_result_o = reg1_i ^ reg2_i;
			end
			mips_pkg::ALU_NOR: begin
				ex_result_o = ~(reg1_i | reg2_i);
			end
			mips_pkg::ALU_SLL: begin
				ex_result_o = reg2_i << shamt;
			end
			mips_pkg::ALU_SRL: begin
				ex_result_o = reg2_i >> shamt;
			end
			mips_pkg::ALU_SRA: begin
				ex_result_o = $signed(reg2_i) >>> shamt;
			end
			mips_pkg::ALU_ADD: begin
				ex_result_o = reg1_i + reg2_i;
			end
			mips_pkg::ALU_SUB: begin
				ex_result_o = reg1_i - reg2_i;
			end
			mips_pkg::ALU_SLT: begin
				ex_result_o = {{(mips_pkg::DATA_W-1){1'b0}}, $signed(reg1_i) < $signed(reg2_i)};
			end
			mips_pkg::ALU_SLTU: begin
				ex_result_o = {{(mips_pkg::DATA_W-1){1'b0}}, reg1_i < reg2_i};
			end
			default: begin
				ex_result_o = '0; // Bubble
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wreg_o <= 1'b0;
		end else begin
			wreg_o <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		wd_o    <= wd_i;
		wdata_o <= ex_result_o;
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
		wreg_o |-> wd_o != '0)
		else $error("write to register 0 reached execute output");

endmodule

// ==== src/result_stage.sv ====
module result_stage (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            wreg_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic [mips_pkg::DATA_W-1:0]     wdata_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0] reg1_addr_i,
	input  logic [mips_pkg::REG_ADDR_W-1:0] reg2_addr_i,
	output logic [mips_pkg::DATA_W-1:0]     reg1_data_o,
	output logic [mips_pkg::DATA_W-1:0]     reg2_data_o,
	output logic                            wb_valid_o,
	output logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [mips_pkg::DATA_W-1:0]     wb_data_o
);

	logic [mips_pkg::DATA_W-1:0] regs [mips_pkg::REG_NUM];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int k = 0; k < mips_pkg::REG_NUM; k++) begin
				regs[k] <= '0;
			end
		end else if (wreg_i) begin
			regs[wd_i] <= wdata_i;
		end
	end

	// Read ports see a write one cycle after it is issued
	assign reg1_data_o = (reg1_addr_i == '0) ? '0 : regs[reg1_addr_i];
	assign reg2_data_o = (reg2_addr_i == '0) ? '0 : regs[reg2_addr_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= wreg_i; // One pulse per write
		end
	end

	always_ff @(posedge clk) begin
		wb_addr_o <= wd_i;
		wb_data_o <= wdata_i;
	end

	a_report_addr: assert property (@(posedge clk) disable iff (reset_i)
		wb_valid_o |-> wb_addr_o != '0)
		else $error("write report for register 0");

endmodule

// ==== src/mips_core.sv ====
module mips_core (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            inst_valid_i,
	input  mips_pkg::inst_u                 inst_i,
	input  logic [mips_pkg::DATA_W-1:0]     pc_i,
	output logic                            branch_o,
	output logic [mips_pkg::DATA_W-1:0]     branch_target_o,
	output logic                            wb_valid_o,
	output logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [mips_pkg::DATA_W-1:0]     wb_data_o
);

	logic [mips_pkg::REG_ADDR_W-1:0] reg1_addr;
	logic [mips_pkg::REG_ADDR_W-1:0] reg2_addr;
	logic [mips_pkg::DATA_W-1:0]     reg1_data;
	logic [mips_pkg::DATA_W-1:0]     reg2_data;
	logic [mips_pkg::ALUOP_W-1:0]    id_aluop;
	logic [mips_pkg::DATA_W-1:0]     id_reg1;
	logic [mips_pkg::DATA_W-1:0]     id_reg2;
	logic [mips_pkg::REG_ADDR_W-1:0] id_wd;
	logic                            id_wreg;
	logic [mips_pkg::DATA_W-1:0]     ex_result;
	logic [mips_pkg::REG_ADDR_W-1:0] ex_wd;
	logic                            ex_wreg;
	logic [mips_pkg::DATA_W-1:0]     ex_wdata;

	decode_stage u_decode (
		.clk(clk), .reset_i(reset_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
		.pc_i(pc_i), .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
		.ex_result_i(ex_result), .mem_wreg_i(ex_wreg), .mem_wd_i(ex_wd),
		.mem_wdata_i(ex_wdata), .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
		.aluop_o(id_aluop), .reg1_o(id_reg1), .reg2_o(id_reg2), .wd_o(id_wd),
		.wreg_o(id_wreg), .branch_o(branch_o), .branch_target_o(branch_target_o)
	);

	execute_stage u_execute (
		.clk(clk), .reset_i(reset_i), .aluop_i(id_aluop), .reg1_i(id_reg1),
		.reg2_i(id_reg2), .wd_i(id_wd), .wreg_i(id_wreg), .ex_result_o(ex_result),
		.wd_o(ex_wd), .wreg_o(ex_wreg), .wdata_o(ex_wdata)
	);

	result_stage u_result (
		.clk(clk), .reset_i(reset_i), .wreg_i(ex_wreg), .wd_i(ex_wd), .wdata_i(ex_wdata),
		.reg1_addr_i(reg1_addr), .reg2_addr_i(reg2_addr), .reg1_data_o(reg1_data),
		.reg2_data_o(reg2_data), .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o)
	);

endmodule

// ==== test/tb_mips_core.sv ====
module tb_mips_core;

	logic                            clk;
	logic                            reset_i;
	logic                            inst_valid_i;
	mips_pkg::inst_u                 inst_i;
	logic [mips_pkg::DATA_W-1:0]     pc_i;
	logic                            branch_o;
	logic [mips_pkg::DATA_W-1:0]     branch_target_o;
	logic                            wb_valid_o;
	logic [mips_pkg::REG_ADDR_W-1:0] wb_addr_o;
	logic [mips_pkg::DATA_W-1:0]     wb_data_o;

	int                              seed = 51;
	int                              cyc = 0;
	int                              last_due = 0;
	logic                            checking = 1'b0;
	logic [mips_pkg::DATA_W-1:0]     pc_next;
	logic [mips_pkg::DATA_W-1:0]     ref_regs [mips_pkg::REG_NUM];
	// Expected reports, keyed by the cycle they are due in
	logic [mips_pkg::REG_ADDR_W-1:0] exp_wb_addr [int];
	logic [mips_pkg::DATA_W-1:0]     exp_wb_data [int];
	logic [mips_pkg::DATA_W-1:0]     exp_br_target [int];

	mips_core u_mips_core (
		.clk(clk), .reset_i(reset_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
		.pc_i(pc_i), .branch_o(branch_o), .branch_target_o(branch_target_o),
		.wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [mips_pkg::DATA_W-1:0] rand_word();
		return $random(seed);
	endfunction

	function automatic mips_pkg::inst_u reg_inst(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		mips_pkg::inst_u w;
		w.r.op    = mips_pkg::OP_SPECIAL;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = shamt;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic mips_pkg::inst_u imm_inst(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		mips_pkg::inst_u w;
		w.i.op  = op;
		w.i.rs  = rs;
		w.i.rt  = rt;
		w.i.imm = imm;
		return w;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_write(input logic [mips_pkg::REG_ADDR_W-1:0] addr,
		input logic [mips_pkg::DATA_W-1:0] data);
		if (addr == '0 && wb_valid_o !== 1'b0) begin
			fail_run($sformatf("** Error at %0t: unexpected write report for r%0d",
				$time, wb_addr_o));
		end else if (addr != '0 && (wb_valid_o !== 1'b1 || wb_addr_o !== addr ||
			wb_data_o !== data)) begin
			fail_run($sformatf("** Error at %0t: write %b r%0d = %h, expected r%0d = %h",
				$time, wb_valid_o, wb_addr_o, wb_data_o, addr, data));
		end
	endtask

	task automatic check_branch(input logic taken, input logic [mips_pkg::DATA_W-1:0] target);
		if (branch_o !== taken || (taken && branch_target_o !== target)) begin
			fail_run($sformatf("** Error at %0t: branch %b to %h, expected %b to %h",
				$time, branch_o, branch_target_o, taken, target));
		end
	endtask

	// A cycle without an entry expects no pulse
	always @(negedge clk) begin
		if (checking) begin
			if (exp_wb_addr.exists(cyc)) begin
				check_write(exp_wb_addr[cyc], exp_wb_data[cyc]);
			end else begin
				check_write('0, '0);
			end
			if (exp_br_target.exists(cyc)) begin
				check_branch(1'b1, exp_br_target[cyc]);
			end else begin
				check_branch(1'b0, '0);
			end
			cyc <= cyc + 1;
		end
	end

	// Program order model where forwarded and file reads look alike
	task automatic predict(input mips_pkg::inst_u inst, input logic [31:0] pc, input int c);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		logic [31:0] res;
		logic        wr;
		logic        taken;
		a     = ref_regs[inst.r.rs];
		b     = ref_regs[inst.r.rt];
		imm_s = {{16{inst.i.imm[15]}}, inst.i.imm};
		res   = '0;
		wr    = 1'b1;
		taken = 1'b0;
		case (inst.i.op)
			mips_pkg::OP_SPECIAL: begin
				case (inst.r.funct)
					mips_pkg::FN_OR:   res = a | b;
					mips_pkg::FN_AND:  res = a & b;
					mips_pkg::FN_XOR:  res = a ^ b;
					mips_pkg::FN_NOR:  res = ~(a | b);
					mips_pkg::FN_SLL:  res = b << inst.r.shamt;
					mips_pkg::FN_SRL:  res = b >> inst.r.shamt;
					mips_pkg::FN_SRA:  res = $signed(b) >>> inst.r.shamt;
					mips_pkg::FN_SLLV: res = b << a[4:0];
					mips_pkg::FN_SRLV: res = b >> a[4:0];
					mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
					mips_pkg::FN_ADDU: res = a + b;
					mips_pkg::FN_SUBU: res = a - b;
					mips_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
					mips_pkg::FN_SLTU: res = {31'd0, a < b};
					default:           wr = 1'b0;
				endcase
			end
			mips_pkg::OP_ORI:   res = a | {16'd0, inst.i.imm};
			mips_pkg::OP_ANDI:  res = a & {16'd0, inst.i.imm};
			mips_pkg::OP_XORI:  res = a ^ {16'd0, inst.i.imm};
			mips_pkg::OP_LUI:   res = {inst.i.imm, 16'd0};
			mips_pkg::OP_ADDIU: res = a + imm_s;
			mips_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(imm_s)};
			mips_pkg::OP_SLTIU: res = {31'd0, a < imm_s};
			mips_pkg::OP_BEQ:   taken = (a == b);
			mips_pkg::OP_BNE:   taken = (a != b);
			mips_pkg::OP_BGTZ:  taken = ($signed(a) > 0);
			mips_pkg::OP_BLEZ:  taken = ($signed(a) <= 0);
			default:            wr = 1'b0; // Unsupported becomes a bubble
		endcase
		if (inst.i.op inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BGTZ,
			mips_pkg::OP_BLEZ}) begin
			wr = 1'b0;
		end
		// Register form writes rd and immediate form writes rt
		if (wr && inst.i.op == mips_pkg::OP_SPECIAL && inst.r.rd != '0) begin
			ref_regs[inst.r.rd] = res;
			exp_wb_addr[c+3]    = inst.r.rd;
			exp_wb_data[c+3]    = res;
		end else if (wr && inst.i.op != mips_pkg::OP_SPECIAL && inst.i.rt != '0) begin
			ref_regs[inst.i.rt] = res;
			exp_wb_addr[c+3]    = inst.i.rt;
			exp_wb_data[c+3]    = res;
		end
		if (taken) begin
			exp_br_target[c+1] = pc + 32'd4 + (imm_s << 2);
		end
		last_due = c + 3;
	endtask

	task automatic issue(input mips_pkg::inst_u inst);
		@(posedge clk);
		inst_valid_i <= 1'b1;
		inst_i       <= inst;
		pc_i         <= pc_next;
		predict(inst, pc_next, cyc);
		pc_next = pc_next + 32'd4;
	endtask

	task automatic bubble();
		@(posedge clk);
		inst_valid_i <= 1'b0;
	endtask

	task automatic issue_spaced(input mips_pkg::inst_u inst);
		issue(inst);
		bubble();
		bubble();
	endtask

	task automatic hold_invalid(input mips_pkg::inst_u inst);
		@(posedge clk);
		inst_valid_i <= 1'b0;
		inst_i       <= inst; // Real instruction ignored without the strobe
		pc_i         <= pc_next;
	endtask

	task automatic branch_random_offset(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt);
		logic [31:0] r;
		r = rand_word();
		issue(imm_inst(op, rs, rt, r[15:0]));
	endtask

	task automatic drain();
		int guard;
		guard = 0;
		bubble();
		while (cyc <= last_due) begin
			@(posedge clk);
			guard++;
			if (guard > 10) begin
				fail_run("Timed out waiting for the pipeline to report its last results");
			end
		end
	endtask

	task automatic test_quiet_after_reset();
		repeat (4) bubble();
	endtask

	task automatic test_immediates();
		logic [31:0] r;
		logic [5:0]  op;
		for (int k = 1; k <= 8; k++) begin
			r = rand_word();
			issue_spaced(imm_inst(mips_pkg::OP_LUI, 5'd0, 5'(k), r[31:16]));
			issue_spaced(imm_inst(mips_pkg::OP_ORI, 5'(k), 5'(k), r[15:0]));
		end
		for (int n = 0; n < 14; n++) begin
			r = rand_word();
			case (n % 7)
				0:       op = mips_pkg::OP_ORI;
				1:       op = mips_pkg::OP_ANDI;
				2:       op = mips_pkg::OP_XORI;
				3:       op = mips_pkg::OP_LUI;
				4:       op = mips_pkg::OP_ADDIU;
				5:       op = mips_pkg::OP_SLTI;
				default: op = mips_pkg::OP_SLTIU;
			endcase
			issue_spaced(imm_inst(op, {2'b00, r[18:16]}, {2'b00, r[21:19]} + 5'd1, r[15:0]));
		end
		drain();
	endtask

	task automatic test_register_ops();
		logic [5:0] fn;
		logic [4:0] dst [16];
		logic [4:0] rs;
		logic [4:0] rt;
		for (int i = 0; i < 16; i++) begin
			case (i % 8)
				0:       fn = mips_pkg::FN_OR;
				1:       fn = mips_pkg::FN_AND;
				2:       fn = mips_pkg::FN_XOR;
				3:       fn = mips_pkg::FN_NOR;
				4:       fn = mips_pkg::FN_ADDU;
				5:       fn = mips_pkg::FN_SUBU;
				6:       fn = mips_pkg::FN_SLT;
				default: fn = mips_pkg::FN_SLTU;
			endcase
			dst[i] = 5'(9 + i % 6);
			rs     = (i >= 1) ? dst[i-1] : 5'd1; // From execute
			if (i >= 3 && i % 3 == 0) begin
				rt = dst[i-3]; // From the register file
			end else begin
				rt = (i >= 2) ? dst[i-2] : 5'd2; // From the execute output register
			end
			issue(reg_inst(fn, rs, rt, dst[i], 5'd0));
		end
		drain();
	endtask

	task automatic test_shifts();
		logic [31:0] r;
		logic [5:0]  fn;
		logic [4:0]  rt;
		r = rand_word();
		issue(imm_inst(mips_pkg::OP_LUI, 5'd0, 5'd15, r[31:16] | 16'h8000)); // Negative
		issue(imm_inst(mips_pkg::OP_ORI, 5'd15, 5'd15, r[15:0]));
		for (int i = 0; i < 12; i++) begin
			r  = rand_word();
			rt = (i < 6) ? 5'd15 : {2'b00, r[23:21]} + 5'd1;
			case (i % 6)
				0:       fn = mips_pkg::FN_SLL;
				1:       fn = mips_pkg::FN_SRL;
				2:       fn = mips_pkg::FN_SRA;
				3:       fn = mips_pkg::FN_SLLV;
				4:       fn = mips_pkg::FN_SRLV;
				default: fn = mips_pkg::FN_SRAV;
			endcase
			if (i % 6 < 3) begin
				issue(reg_inst(fn, 5'd0, rt, 5'(16 + i % 4), r[4:0]));
			end else begin
				issue(imm_inst(mips_pkg::OP_ADDIU, 5'd0, 5'd21, r[15:0])); // Amount in low bits
				issue(reg_inst(fn, 5'd21, rt, 5'(16 + i % 4), 5'd0));
			end
		end
		drain();
	endtask

	task automatic test_branches();
		logic [31:0] r;
		r = rand_word();
		issue(imm_inst(mips_pkg::OP_LUI, 5'd0, 5'd22, r[31:16] & 16'h7fff));
		issue(imm_inst(mips_pkg::OP_ORI, 5'd22, 5'd22, r[15:0] | 16'h0001));
		issue(reg_inst(mips_pkg::FN_ADDU, 5'd22, 5'd0, 5'd23, 5'd0));
		issue(imm_inst(mips_pkg::OP_ADDIU, 5'd22, 5'd24, 16'h0010));
		branch_random_offset(mips_pkg::OP_BEQ, 5'd22, 5'd23);
		branch_random_offset(mips_pkg::OP_BEQ, 5'd22, 5'd24);
		branch_random_offset(mips_pkg::OP_BNE, 5'd22, 5'd24);
		branch_random_offset(mips_pkg::OP_BNE, 5'd22, 5'd23);
		branch_random_offset(mips_pkg::OP_BGTZ, 5'd22, 5'd0);
		branch_random_offset(mips_pkg::OP_BGTZ, 5'd0, 5'd0);
		branch_random_offset(mips_pkg::OP_BGTZ, 5'd15, 5'd0);
		branch_random_offset(mips_pkg::OP_BLEZ, 5'd15, 5'd0);
		branch_random_offset(mips_pkg::OP_BLEZ, 5'd0, 5'd0);
		branch_random_offset(mips_pkg::OP_BLEZ, 5'd22, 5'd0);
		issue(imm_inst(mips_pkg::OP_ADDIU, 5'd0, 5'd26, 16'h0007));
		branch_random_offset(mips_pkg::OP_BGTZ, 5'd26, 5'd0); // Operand forwarded
		issue(imm_inst(mips_pkg::OP_ADDIU, 5'd0, 5'd26, 16'hfff0));
		branch_random_offset(mips_pkg::OP_BLEZ, 5'd26, 5'd0);
		drain();
	endtask

	task automatic test_bubbles();
		issue(imm_inst(mips_pkg::OP_ADDIU, 5'd0, 5'd27, 16'h5a5a));
		issue(imm_inst(mips_pkg::OP_ADDIU, 5'd5, 5'd0, 16'h1234)); // Write to r0 dropped
		issue(reg_inst(mips_pkg::FN_OR, 5'd0, 5'd0, 5'd27, 5'd0));
		issue(imm_inst(6'b100011, 5'd1, 5'd5, 16'h0004)); // Unsupported LW
		issue(reg_inst(6'b011000, 5'd1, 5'd2, 5'd5, 5'd0)); // Unsupported MULT
		hold_invalid(imm_inst(mips_pkg::OP_ORI, 5'd1, 5'd5, 16'hffff));
		bubble();
		bubble();
		issue(reg_inst(mips_pkg::FN_ADDU, 5'd0, 5'd0, 5'd28, 5'd0));
		drain();
	endtask

	initial begin
		reset_i      = 1'b1;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		pc_next      = rand_word() & 32'hffff_fffc;
		for (int k = 0; k < mips_pkg::REG_NUM; k++) begin
			ref_regs[k] = '0;
		end
		@(posedge clk);
		checking <= 1'b1; // Outputs are known after the first reset edge
		repeat (15) @(posedge clk);
		reset_i <= 1'b0;
		test_quiet_after_reset();
		test_immediates();
		test_register_ops();
		test_shifts();
		test_branches();
		test_bubbles();
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== mips_core.f ====
src/mips_pkg.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mips_core.sv
test/tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
BUILD_DIR ?= build
FILELIST  ?= mips_core.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, BUILD_DIR, FILELIST, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
